// ==== cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// one word per line and byte addresses of that same width
`define CACHE_DATA_W 32
`define CACHE_SET_W 2
`define CACHE_TAG_W (`CACHE_DATA_W - `CACHE_SET_W - 2)

// 256 words of backing store, decoded from address bits 9..2
`define CACHE_MEM_AW 8
`define CACHE_WAYS 2

`endif

// ==== rtl/cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cache_op_e;

    typedef struct packed {
        logic                     valid;
        cache_op_e                op;
        logic [`CACHE_TAG_W-1:0]  tag;
        logic [`CACHE_SET_W-1:0]  set;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic [3:0]               byte_en;
    } mem_req_t;

    typedef struct packed {
        logic                     dirty;
        logic                     valid;
        logic [`CACHE_TAG_W-1:0]  tag;
        logic [`CACHE_DATA_W-1:0] data;
    } cache_way_t;

    // way0 always holds the most recently allocated line
    typedef struct packed {
        cache_way_t way0;
        cache_way_t way1;
    } cache_set_t;

    typedef struct packed {
        mem_req_t                         req;
        cache_set_t                       line;
        logic                             hit;
        logic [$clog2(`CACHE_WAYS)-1:0]   hit_way;
    } lookup_t;

    typedef struct packed {
        logic                     valid;
        logic [`CACHE_DATA_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] data;
    } writeback_t;

endpackage

// ==== rtl/req_capture.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module req_capture (
    input  logic                     CLK,
    input  logic                     RST,
    input  logic                     mem_read,
    input  logic                     mem_write,
    input  logic [`CACHE_DATA_W-1:0] addr,
    input  logic [`CACHE_DATA_W-1:0] wdata,
    input  logic [3:0]               byte_en,
    output cache_pkg::mem_req_t      req
);

    logic strobe;

    assign strobe = mem_read | mem_write;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            req <= '0;
        end else begin
            req.valid <= strobe;
            // a write wins when both strobes are raised together
            if (mem_write) begin
                req.op <= cache_pkg::OP_WRITE;
            end else begin
                req.op <= cache_pkg::OP_READ;
            end
            req.tag     <= addr[`CACHE_DATA_W-1:`CACHE_SET_W+2];
            req.set     <= addr[`CACHE_SET_W+1:2];
            req.wdata   <= wdata;
            req.byte_en <= byte_en;
        end
    end

endmodule

// ==== rtl/set_array.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module set_array (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic [`CACHE_SET_W-1:0] rd_set,
    output cache_pkg::cache_set_t   rd_line,
    input  logic                    wr_en,
    input  logic [`CACHE_SET_W-1:0] wr_set,
    input  cache_pkg::cache_set_t   wr_line
);

    localparam int NUM_SETS = 2 ** `CACHE_SET_W;

    cache_pkg::cache_set_t sets [NUM_SETS];

    // reset leaves every way invalid and clean
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                sets[i] <= '0;
            end
        end else if (wr_en) begin
            sets[wr_set] <= wr_line;
        end
    end

    assign rd_line = sets[rd_set];

endmodule

// ==== rtl/tag_lookup.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module tag_lookup (
    input  logic                    CLK,
    input  logic                    RST,
    input  cache_pkg::mem_req_t     req,
    output logic [`CACHE_SET_W-1:0] rd_set,
    input  cache_pkg::cache_set_t   rd_line,
    input  logic                    fwd_en,
    input  logic [`CACHE_SET_W-1:0] fwd_set,
    input  cache_pkg::cache_set_t   fwd_line,
    output cache_pkg::lookup_t      lookup
);

    cache_pkg::cache_set_t cur_line;
    logic                  use_fwd;
    logic                  hit0;
    logic                  hit1;

    assign rd_set = req.set;

    // the set being written at the coming edge is newer than the array copy
    assign use_fwd  = fwd_en && (fwd_set == req.set);
    assign cur_line = use_fwd ? fwd_line : rd_line;

    assign hit0 = req.valid && cur_line.way0.valid && (cur_line.way0.tag == req.tag);
    assign hit1 = req.valid && cur_line.way1.valid && (cur_line.way1.tag == req.tag);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            lookup <= '0;
        end else begin
            lookup.req  <= req;
            lookup.line <= cur_line;
            lookup.hit  <= hit0 | hit1;
            // a tag lives in at most one way, so way 1 only when way 0 missed
            lookup.hit_way <= hit1 & ~hit0;
        end
    end

endmodule

// ==== rtl/line_update.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module line_update (
    input  logic                     CLK,
    input  logic                     RST,
    input  cache_pkg::lookup_t       lookup,
    output logic                     wr_en,
    output logic [`CACHE_SET_W-1:0]  wr_set,
    output cache_pkg::cache_set_t    wr_line,
    output logic [`CACHE_MEM_AW-1:0] fill_addr,
    input  logic [`CACHE_DATA_W-1:0] fill_data,
    output cache_pkg::writeback_t    wb,
    output logic                     resp_valid,
    output logic                     hit,
    output logic [`CACHE_DATA_W-1:0] rd
);

    cache_pkg::mem_req_t      req;
    cache_pkg::cache_set_t    old_line;
    cache_pkg::cache_set_t    new_line;
    cache_pkg::writeback_t    victim;
    logic                     is_write;
    logic [`CACHE_DATA_W-1:0] base_word;
    logic [`CACHE_DATA_W-1:0] new_word;

    function automatic logic [`CACHE_DATA_W-1:0] merge_bytes(
        input logic [`CACHE_DATA_W-1:0] old_word,
        input logic [`CACHE_DATA_W-1:0] wr_word,
        input logic [3:0]               be
    );
        logic [`CACHE_DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[b*8 +: 8] = wr_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    assign req      = lookup.req;
    assign old_line = lookup.line;
    assign is_write = (req.op == cache_pkg::OP_WRITE);

    // word address of the requested line, bits 9..2 of the byte address
    assign fill_addr = {req.tag[`CACHE_MEM_AW-`CACHE_SET_W-1:0], req.set};

    always_comb begin
        if (!lookup.hit) begin
            base_word = fill_data;
        end else if (lookup.hit_way != '0) begin
            base_word = old_line.way1.data;
        end else begin
            base_word = old_line.way0.data;
        end
        new_word = is_write ? merge_bytes(base_word, req.wdata, req.byte_en) : base_word;

        new_line = old_line;
        victim   = '0;
        if (lookup.hit) begin
            if (lookup.hit_way != '0) begin
                new_line.way1.data  = new_word;
                new_line.way1.dirty = old_line.way1.dirty | is_write;
            end else begin
                new_line.way0.data  = new_word;
                new_line.way0.dirty = old_line.way0.dirty | is_write;
            end
        end else begin
            // allocate into way 0 and push the older line down
            new_line.way1       = old_line.way0;
            new_line.way0.valid = 1'b1;
            new_line.way0.dirty = is_write;
            new_line.way0.tag   = req.tag;
            new_line.way0.data  = new_word;
            victim.valid = req.valid && old_line.way1.valid && old_line.way1.dirty;
            victim.addr  = {old_line.way1.tag, req.set, 2'b00};
            victim.data  = old_line.way1.data;
        end
    end

    assign wr_en   = req.valid;
    assign wr_set  = req.set;
    assign wr_line = new_line;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            resp_valid <= 1'b0;
            hit        <= 1'b0;
            rd         <= '0;
            wb         <= '0;
        end else begin
            resp_valid <= req.valid;
            hit        <= req.valid & lookup.hit;
            wb         <= victim;
            if (req.valid) begin
                rd <= new_word;
            end
        end
    end

endmodule

// ==== rtl/backing_memory.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module backing_memory (
    input  logic                     CLK,
    input  logic                     RST,
    input  logic [`CACHE_MEM_AW-1:0] rd_addr,
    output logic [`CACHE_DATA_W-1:0] rd_data,
    input  cache_pkg::writeback_t    wb
);

    localparam int DEPTH = 2 ** `CACHE_MEM_AW;

    logic [`CACHE_DATA_W-1:0] mem [DEPTH];
    logic [`CACHE_MEM_AW-1:0] wb_word;

    assign wb_word = wb.addr[`CACHE_MEM_AW+1:2];

    // the writeback arrives one edge after its eviction, so a fill of that
    // same word in the meantime has to take the data from the writeback
    assign rd_data = (wb.valid && (wb_word == rd_addr)) ? wb.data : mem[rd_addr];

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wb.valid) begin
            mem[wb_word] <= wb.data;
        end
    end

endmodule

// ==== rtl/cache_subsystem.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_subsystem (
    input  logic                     CLK,
    input  logic                     RST,
    input  logic                     mem_read,
    input  logic                     mem_write,
    input  logic [`CACHE_DATA_W-1:0] addr,
    input  logic [`CACHE_DATA_W-1:0] wdata,
    input  logic [3:0]               byte_en,
    output logic                     resp_valid,
    output logic                     hit,
    output logic [`CACHE_DATA_W-1:0] rd,
    output logic                     wb_valid,
    output logic [`CACHE_DATA_W-1:0] wb_addr,
    output logic [`CACHE_DATA_W-1:0] wb_data
);

    cache_pkg::mem_req_t      req;
    cache_pkg::lookup_t       lookup;
    cache_pkg::cache_set_t    rd_line;
    cache_pkg::cache_set_t    wr_line;
    cache_pkg::writeback_t    wb;
    logic [`CACHE_SET_W-1:0]  rd_set;
    logic [`CACHE_SET_W-1:0]  wr_set;
    logic                     wr_en;
    logic [`CACHE_MEM_AW-1:0] fill_addr;
    logic [`CACHE_DATA_W-1:0] fill_data;

    req_capture req_capture_inst (
        .CLK(CLK), .RST(RST), .mem_read(mem_read), .mem_write(mem_write),
        .addr(addr), .wdata(wdata), .byte_en(byte_en), .req(req)
    );

    set_array set_array_inst (
        .CLK(CLK), .RST(RST), .rd_set(rd_set), .rd_line(rd_line),
        .wr_en(wr_en), .wr_set(wr_set), .wr_line(wr_line)
    );

    // the update stage feeds its new set straight back as the forward path
    tag_lookup tag_lookup_inst (
        .CLK(CLK), .RST(RST), .req(req), .rd_set(rd_set), .rd_line(rd_line),
        .fwd_en(wr_en), .fwd_set(wr_set), .fwd_line(wr_line), .lookup(lookup)
    );

    line_update line_update_inst (
        .CLK(CLK), .RST(RST), .lookup(lookup), .wr_en(wr_en), .wr_set(wr_set),
        .wr_line(wr_line), .fill_addr(fill_addr), .fill_data(fill_data), .wb(wb),
        .resp_valid(resp_valid), .hit(hit), .rd(rd)
    );

    backing_memory backing_memory_inst (
        .CLK(CLK), .RST(RST), .rd_addr(fill_addr), .rd_data(fill_data), .wb(wb)
    );

    assign wb_valid = wb.valid;
    assign wb_addr  = wb.addr;
    assign wb_data  = wb.data;

endmodule

// ==== bench/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

    typedef struct packed {
        logic        resp_valid;
        logic        hit;
        logic [31:0] rd;
        logic        wb_valid;
        logic [31:0] wb_addr;
        logic [31:0] wb_data;
    } expect_t;

    logic        CLK;
    logic        RST;
    logic        mem_read;
    logic        mem_write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  byte_en;
    logic        resp_valid;
    logic        hit;
    logic [31:0] rd;
    logic        wb_valid;
    logic [31:0] wb_addr;
    logic [31:0] wb_data;

    // reference copy of both ways of every set and of the next-level memory
    logic        m_valid [4][2];
    logic        m_dirty [4][2];
    logic [27:0] m_tag [4][2];
    logic [31:0] m_data [4][2];
    logic [31:0] m_mem [256];
    expect_t     pending [$];

    cache_subsystem cache_subsystem_inst (
        .CLK(CLK), .RST(RST), .mem_read(mem_read), .mem_write(mem_write), .addr(addr),
        .wdata(wdata), .byte_en(byte_en), .resp_valid(resp_valid), .hit(hit), .rd(rd),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    always #4 CLK = ~CLK;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            report_failure($sformatf("ERROR %s expected %h actual %h", name, exp_v, act_v));
        end
    endtask

    function automatic logic [31:0] apply_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [31:0] line_addr(input logic [5:0] tag, input logic [1:0] set);
        return {22'b0, tag, set, 2'b00};
    endfunction

    // runs one request to completion in program order and writes any victim to memory at once
    task automatic model_access(input logic is_wr, input logic [31:0] a, input logic [31:0] wd,
                                input logic [3:0] be, output expect_t e);
        logic [1:0]  s;
        logic [27:0] t;
        logic [31:0] fill;
        int          w;
        e = '0;
        s = a[3:2];
        t = a[31:4];
        w = -1;
        e.resp_valid = 1'b1;
        if (m_valid[s][0] && m_tag[s][0] == t) begin
            w = 0;
        end else if (m_valid[s][1] && m_tag[s][1] == t) begin
            w = 1;
        end
        if (w >= 0) begin
            e.hit = 1'b1;
            if (is_wr) begin
                m_data[s][w]  = apply_bytes(m_data[s][w], wd, be);
                m_dirty[s][w] = 1'b1;
            end
            e.rd = m_data[s][w];
        end else begin
            fill = m_mem[a[9:2]];
            if (m_valid[s][1] && m_dirty[s][1]) begin
                e.wb_valid = 1'b1;
                e.wb_addr  = {m_tag[s][1], s, 2'b00};
                e.wb_data  = m_data[s][1];
                m_mem[e.wb_addr[9:2]] = m_data[s][1];
            end
            m_valid[s][1] = m_valid[s][0];
            m_dirty[s][1] = m_dirty[s][0];
            m_tag[s][1]   = m_tag[s][0];
            m_data[s][1]  = m_data[s][0];
            m_valid[s][0] = 1'b1;
            m_dirty[s][0] = is_wr;
            m_tag[s][0]   = t;
            m_data[s][0]  = is_wr ? apply_bytes(fill, wd, be) : fill;
            e.rd = m_data[s][0];
        end
    endtask

    // responses come out three edges after the request is driven
    task automatic step(input logic rd_s, input logic wr_s, input logic [31:0] a,
                        input logic [31:0] wd, input logic [3:0] be);
        expect_t e;
        @(posedge CLK);
        #1;
        e = pending.pop_front();
        check_value("resp_valid", 32'(e.resp_valid), 32'(resp_valid));
        check_value("hit", 32'(e.hit), 32'(hit));
        check_value("wb_valid", 32'(e.wb_valid), 32'(wb_valid));
        if (e.resp_valid) begin
            check_value("rd", e.rd, rd);
        end
        if (e.wb_valid) begin
            check_value("wb_addr", e.wb_addr, wb_addr);
            check_value("wb_data", e.wb_data, wb_data);
        end
        mem_read  = rd_s;
        mem_write = wr_s;
        addr      = a;
        wdata     = wd;
        byte_en   = be;
        e = '0;
        if (rd_s || wr_s) begin
            model_access(wr_s, a, wd, be, e);
        end
        pending.push_back(e);
    endtask

    initial begin
        logic [31:0] r;
        logic [2:0]  kind;
        void'($urandom(32'h88b7_93c3));
        CLK       = 1'b0;
        RST       = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        addr      = '0;
        wdata     = '0;
        byte_en   = '0;
        for (int s = 0; s < 4; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_data[s][w]  = '0;
            end
        end
        for (int i = 0; i < 256; i++) begin
            m_mem[i] = '0;
        end
        repeat (2) begin
            @(posedge CLK);
            #1;
            check_value("resp_valid", 32'h0, 32'(resp_valid));
            check_value("wb_valid", 32'h0, 32'(wb_valid));
            check_value("hit", 32'h0, 32'(hit));
            check_value("rd", 32'h0, rd);
        end
        RST = 1'b0;
        repeat (3) pending.push_back('0);

        step(1'b1, 1'b0, line_addr(6'd3, 2'd1), 32'h0, 4'h0);
        // partial write miss, read back, then a write hit on the top byte only
        step(1'b0, 1'b1, line_addr(6'd5, 2'd2), 32'ha1b2_c3d4, 4'b0101);
        step(1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
        step(1'b1, 1'b0, line_addr(6'd5, 2'd2), 32'h0, 4'h0);
        step(1'b0, 1'b1, line_addr(6'd5, 2'd2), 32'h1122_3344, 4'b1000);
        step(1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
        step(1'b1, 1'b0, line_addr(6'd5, 2'd2), 32'h0, 4'h0);
        step(1'b0, 1'b1, line_addr(6'd7, 2'd0), 32'h0707_0707, 4'hf);
        step(1'b0, 1'b1, line_addr(6'd9, 2'd0), 32'h0909_0909, 4'hf);
        step(1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
        step(1'b1, 1'b0, line_addr(6'd7, 2'd0), 32'h0, 4'h0);
        step(1'b1, 1'b0, line_addr(6'd9, 2'd0), 32'h0, 4'h0);
        // dirty victims first, then clean ones, then refetch the first victim
        step(1'b0, 1'b1, line_addr(6'd11, 2'd0), 32'h0b0b_0b0b, 4'hf);
        step(1'b1, 1'b0, line_addr(6'd13, 2'd0), 32'h0, 4'h0);
        step(1'b1, 1'b0, line_addr(6'd15, 2'd0), 32'h0, 4'h0);
        step(1'b1, 1'b0, line_addr(6'd17, 2'd0), 32'h0, 4'h0);
        step(1'b1, 1'b0, line_addr(6'd7, 2'd0), 32'h0, 4'h0);
        step(1'b0, 1'b1, line_addr(6'd20, 2'd3), 32'hdead_beef, 4'hf);
        step(1'b0, 1'b1, line_addr(6'd21, 2'd3), 32'hcafe_f00d, 4'b0110);
        step(1'b1, 1'b0, line_addr(6'd20, 2'd3), 32'h0, 4'h0);
        step(1'b1, 1'b1, line_addr(6'd22, 2'd3), 32'h5a5a_a5a5, 4'b1001);
        step(1'b1, 1'b0, line_addr(6'd20, 2'd3), 32'h0, 4'h0);

        for (int n = 0; n < 400; n++) begin
            r    = $urandom;
            kind = r[8:6];
            step((kind >= 3'd2 && kind <= 3'd4) || kind == 3'd7, kind >= 3'd5,
                 {22'b0, r[1:0], 4'b0110, r[3:2], r[5:4]}, $urandom, r[12:9]);
        end

        // the last three requests leave the pipeline at the fixed latency
        repeat (3) begin
            step(1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
rtl/cache_pkg.sv
rtl/req_capture.sv
rtl/set_array.sv
rtl/tag_lookup.sv
rtl/line_update.sv
rtl/backing_memory.sv
rtl/cache_subsystem.sv
bench/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f list.f --top-module cache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi
out=$(./obj_dir/Vcache_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    exit 1
fi
echo "$out" | grep -q "^TESTS PASSED$" || exit 1
exit 0
